//--- hdl/uart_pkg.sv
////////////////////////////////////////////////////////////
// UART framing package
// Serial frame constants and the receiver state encoding
// shared by the 8N1 core and the receive FIFO
////////////////////////////////////////////////////////////

package uart_pkg;

    // Payload bits in one character
    localparam int data_bits = 8;

    // Start bit, payload and one stop bit
    localparam int frame_bits = data_bits + 2;

    // Receiver FSM states
    typedef enum logic [1:0] {
        // Line idle, waiting for a falling edge
        rx_idle  = 2'd0,
        // Waiting half a bit to reach mid start bit
        rx_start = 2'd1,
        // Sampling payload bits, LSB first
        rx_data  = 2'd2,
        // Sampling the stop bit
        rx_stop  = 2'd3
    } rx_state_e;

endpackage : uart_pkg

//--- hdl/bus_pkg.sv
////////////////////////////////////////////////////////////
// Register bus package
// Bus widths, register map and status bit layout
////////////////////////////////////////////////////////////

package bus_pkg;

    localparam int addr_width = 2;
    localparam int bus_width  = 8;

    // Register map
    typedef enum logic [addr_width-1:0] {
        // Write sends a byte, read pops the receive FIFO
        addr_data   = 2'd0,
        // Read returns flags, write clears overflow
        addr_status = 2'd1
    } reg_addr_e;

    // Status register bit positions
    localparam int stat_tx_busy     = 0;
    localparam int stat_rx_avail    = 1;
    localparam int stat_rx_overflow = 2;

endpackage : bus_pkg

//--- hdl/uart_core.sv
////////////////////////////////////////////////////////////
// UART 8N1 core
// One shared baud down-counter, a receive FSM and a
// ten-bit transmit shifter; rates fixed by parameters
////////////////////////////////////////////////////////////

module uart_core #(
    parameter int clk_freq_hz = 1_000_000,
    parameter int baud_rate   = 100_000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rx,
    output logic                          tx,
    input  logic                          tx_start,
    input  logic [uart_pkg::data_bits-1:0] tx_byte,
    output logic                          tx_busy,
    output logic                          rx_valid,
    output logic [uart_pkg::data_bits-1:0] rx_byte
);

    import uart_pkg::*;

    // Clocks per bit
    localparam int divider = clk_freq_hz / baud_rate;
    // One extra bit so the sign can flag the tick
    localparam int cnt_w   = $clog2(divider) + 1;
    localparam int idx_w   = $clog2(data_bits);
    localparam int txc_w   = $clog2(frame_bits + 1);

    // Counter passes through zero to -1, hence the offset of two
    localparam logic signed [cnt_w-1:0] full_reload = cnt_w'(divider - 2);
    localparam logic signed [cnt_w-1:0] half_reload = cnt_w'(divider / 2 - 2);

    logic signed [cnt_w-1:0]  baud_cnt;
    logic                     tick;

    rx_state_e                rx_state;
    logic [idx_w-1:0]         rx_idx;
    logic [data_bits-1:0]     rx_shift;

    logic [frame_bits-1:0]    tx_shift;
    logic [txc_w-1:0]         tx_cnt;

    // Negative count marks the end of a bit period
    assign tick = baud_cnt[cnt_w-1];

    // Shared baud counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_cnt <= full_reload;
        end else if (rx_state == rx_idle && !rx) begin
            // Falling edge on idle line: aim for mid start bit
            baud_cnt <= half_reload;
        end else if (tick || tx_start) begin
            baud_cnt <= full_reload;
        end else begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    // Receive FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_state <= rx_idle;
            rx_idx   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (rx_state)
                rx_idle: begin
                    if (!rx) rx_state <= rx_start;
                end
                rx_start: begin
                    if (tick) begin
                        rx_state <= rx_data;
                        rx_idx   <= '0;
                    end
                end
                rx_data: begin
                    if (tick) begin
                        rx_idx <= rx_idx + 1'b1;
                        if (rx_idx == idx_w'(data_bits - 1)) rx_state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (tick) begin
                        // Byte delivered only with a valid stop bit
                        rx_valid <= rx;
                        rx_state <= rx_idle;
                    end
                end
                default: rx_state <= rx_idle;
            endcase
        end
    end

    // Payload shifter, LSB arrives first
    always_ff @(posedge clk) begin
        if (rx_state == rx_data && tick) rx_shift <= {rx, rx_shift[data_bits-1:1]};
    end

    // Shifter is stable while in stop and idle
    assign rx_byte = rx_shift;

    // Transmit shifter, frame is {stop, data, start}
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_shift <= '1;
            tx_cnt   <= '0;
        end else if (tx_start) begin
            tx_shift <= {1'b1, tx_byte, 1'b0};
            tx_cnt   <= txc_w'(frame_bits);
        end else if (tick && tx_cnt != '0) begin
            tx_shift <= {1'b1, tx_shift[frame_bits-1:1]};
            tx_cnt   <= tx_cnt - 1'b1;
        end
    end

    assign tx      = tx_shift[0];
    assign tx_busy = (tx_cnt != '0);

endmodule : uart_core

//--- hdl/uart_rx_fifo.sv
////////////////////////////////////////////////////////////
// Receive FIFO
// Circular buffer for received bytes; pushes into a full
// buffer are dropped and latch a sticky overflow flag
////////////////////////////////////////////////////////////

module uart_rx_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  logic [uart_pkg::data_bits-1:0] push_data,
    input  logic                           pop,
    output logic [uart_pkg::data_bits-1:0] head,
    output logic                           empty,
    output logic                           overflow,
    input  logic                           clr_overflow
);

    import uart_pkg::*;

    localparam int aw = $clog2(fifo_depth);

    logic [data_bits-1:0] mem [fifo_depth];
    // Extra MSB tells full from empty
    logic [aw:0]          wr_ptr;
    logic [aw:0]          rd_ptr;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

    // Pop of an empty FIFO is ignored
    assign do_pop  = pop && !empty;
    assign do_push = push && !full;

    assign head = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr[aw-1:0]] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            // A lost byte wins over a clear in the same cycle
            if (push && full) begin
                overflow <= 1'b1;
            end else if (clr_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule : uart_rx_fifo

//--- hdl/uart_regs.sv
////////////////////////////////////////////////////////////
// UART register front end
// Decodes single-cycle bus accesses into transmit starts,
// FIFO pops, overflow clears and registered reads
////////////////////////////////////////////////////////////

module uart_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sel,
    input  logic                            we,
    input  logic [bus_pkg::addr_width-1:0]  addr,
    input  logic [bus_pkg::bus_width-1:0]   wdata,
    output logic [bus_pkg::bus_width-1:0]   rdata,
    output logic                            rvalid,
    output logic                            tx_start,
    output logic [uart_pkg::data_bits-1:0]  tx_byte,
    input  logic                            tx_busy,
    output logic                            fifo_pop,
    input  logic [uart_pkg::data_bits-1:0]  fifo_head,
    input  logic                            fifo_empty,
    input  logic                            fifo_overflow,
    output logic                            clr_overflow
);

    import bus_pkg::*;

    reg_addr_e             reg_addr;
    logic                  wr_data;
    logic                  rd_data;
    logic                  tx_pending;
    logic [bus_width-1:0]  status;

    assign reg_addr = reg_addr_e'(addr);

    // Access decode
    assign wr_data      = sel && we && (reg_addr == addr_data);
    assign rd_data      = sel && !we && (reg_addr == addr_data);
    assign clr_overflow = sel && we && (reg_addr == addr_status);

    // Pop only when the read finds data
    assign fifo_pop = rd_data && !fifo_empty;

    // Start pulse is in flight one cycle before the core shows busy
    assign tx_pending = tx_busy || tx_start;

    always_comb begin
        status                   = '0;
        status[stat_tx_busy]     = tx_pending;
        status[stat_rx_avail]    = !fifo_empty;
        status[stat_rx_overflow] = fifo_overflow;
    end

    // Transmit strobe, writes during a frame are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= wr_data && !tx_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_data && !tx_pending) tx_byte <= wdata;
    end

    // Read path, data valid one cycle after select
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= sel && !we;
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !we) begin
            case (reg_addr)
                // Empty FIFO reads as zero
                addr_data:   rdata <= fifo_empty ? '0 : fifo_head;
                addr_status: rdata <= status;
                default:     rdata <= '0;
            endcase
        end
    end

endmodule : uart_regs

//--- hdl/uart_periph.sv
////////////////////////////////////////////////////////////
// UART peripheral top
// Wires the 8N1 core, the receive FIFO and the register
// front end; sets clock, baud and FIFO parameters
////////////////////////////////////////////////////////////

module uart_periph #(
    parameter int clk_freq_hz = 1_000_000,
    parameter int baud_rate   = 100_000,
    parameter int fifo_depth  = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           sel,
    input  logic                           we,
    input  logic [bus_pkg::addr_width-1:0] addr,
    input  logic [bus_pkg::bus_width-1:0]  wdata,
    output logic [bus_pkg::bus_width-1:0]  rdata,
    output logic                           rvalid,
    output logic                           tx,
    input  logic                           rx
);

    import uart_pkg::*;

    // Core to register block
    logic                 tx_start;
    logic [data_bits-1:0] tx_byte;
    logic                 tx_busy;

    // Core to FIFO
    logic                 rx_valid;
    logic [data_bits-1:0] rx_byte;

    // FIFO to register block
    logic                 fifo_pop;
    logic [data_bits-1:0] fifo_head;
    logic                 fifo_empty;
    logic                 fifo_overflow;
    logic                 clr_overflow;

    uart_core #(
        .clk_freq_hz (clk_freq_hz),
        .baud_rate   (baud_rate)
    ) i_uart_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .tx       (tx),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    uart_rx_fifo #(
        .fifo_depth (fifo_depth)
    ) i_uart_rx_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (rx_valid),
        .push_data    (rx_byte),
        .pop          (fifo_pop),
        .head         (fifo_head),
        .empty        (fifo_empty),
        .overflow     (fifo_overflow),
        .clr_overflow (clr_overflow)
    );

    uart_regs i_uart_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .sel           (sel),
        .we            (we),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .rvalid        (rvalid),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .tx_busy       (tx_busy),
        .fifo_pop      (fifo_pop),
        .fifo_head     (fifo_head),
        .fifo_empty    (fifo_empty),
        .fifo_overflow (fifo_overflow),
        .clr_overflow  (clr_overflow)
    );

endmodule : uart_periph

//--- verif/tb_clock_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset
// Free-running clock, reset held low for a set number of cycles
////////////////////////////////////////////////////////////

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Release shortly after an edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule : tb_clock_gen

//--- verif/uart_core_asserts.sv
////////////////////////////////////////////////////////////
// UART core assertions
// Idle line level, receive strobe width and transmit start
////////////////////////////////////////////////////////////

module uart_core_asserts (
    input logic clk,
    input logic rst_n,
    input logic tx,
    input logic tx_start,
    input logic tx_busy,
    input logic rx_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failures so far, read by the testbench at the end of the run
    int fail_count = 0;

    // Idle transmitter holds the line at mark
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while the transmitter is idle");
        end

    // Receive strobe is a single-cycle pulse
    rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx_valid held for more than one cycle");
        end

    // Start from idle shows busy on the next cycle
    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_start && !tx_busy) |=> tx_busy)
        else begin
            fail_count++;
            $error("tx_busy did not rise after tx_start");
        end

endmodule : uart_core_asserts

bind uart_core uart_core_asserts i_uart_core_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx       (tx),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .rx_valid (rx_valid)
);

//--- verif/tb_uart_periph.sv
////////////////////////////////////////////////////////////
// UART peripheral testbench
// Table of bus and serial operations applied in a loop,
// with a serial line model, bus tasks and a watchdog
////////////////////////////////////////////////////////////

module tb_uart_periph;

    timeunit 1ns;
    timeprecision 1ps;

    import bus_pkg::*;

    localparam int clk_freq_hz = 1_000_000;
    localparam int baud_rate   = 100_000;
    localparam int fifo_depth  = 4;
    localparam int divider     = clk_freq_hz / baud_rate;
    localparam int n_rows      = 6;
    // Status values from the register map bit positions
    localparam logic [7:0] st_busy  = 8'(1 << stat_tx_busy);
    localparam logic [7:0] st_avail = 8'(1 << stat_rx_avail);
    localparam logic [7:0] st_ovf   = 8'(1 << stat_rx_overflow);

    typedef enum logic [1:0] {op_transmit, op_receive, op_burst, op_busy_write} op_e;

    // Status field is the value expected at the row's key point
    typedef struct packed {
        op_e        op;
        logic [7:0] data;
        logic [7:0] count;
        logic [7:0] status;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  sel;
    logic                  we;
    logic [addr_width-1:0] addr;
    logic [7:0]            wdata;
    logic [7:0]            rdata;
    logic                  rvalid;
    logic                  tx;
    logic                  rx;

    row_t        rows [n_rows];
    int          value_errors = 0;
    int          other_errors = 0;
    logic [31:0] lcg_state    = 32'h2ac5_f70d;

    tb_clock_gen #(
        .period_ns    (10),
        .reset_cycles (10)
    ) i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart_periph #(
        .clk_freq_hz (clk_freq_hz),
        .baud_rate   (baud_rate),
        .fifo_depth  (fifo_depth)
    ) i_uart_periph (
        .clk    (clk),
        .rst_n  (rst_n),
        .sel    (sel),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .rvalid (rvalid),
        .tx     (tx),
        .rx     (rx)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0d ns: %s, got %02h expected %02h",
                     $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input logic [addr_width-1:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        sel   = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #1;
        sel = 1'b0;
    endtask

    // Read data must come with a one-cycle rvalid pulse after the select
    task automatic bus_read(input logic [addr_width-1:0] a, output logic [7:0] d);
        @(posedge clk);
        #1;
        assert (rvalid === 1'b0) else begin
            other_errors++;
            $display("ERROR at %0d ns: rvalid high with no read in the cycle before", $time);
        end
        sel  = 1'b1;
        we   = 1'b0;
        addr = a;
        @(posedge clk);
        #1;
        sel = 1'b0;
        assert (rvalid === 1'b1) else begin
            other_errors++;
            $display("ERROR at %0d ns: rvalid did not pulse one cycle after the select", $time);
        end
        d = rdata;
    endtask

    // Serial line model sends start bit, data LSB first and stop bit
    task automatic send_serial(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            rx = frame[i];
            repeat (divider - 1) @(posedge clk);
        end
    endtask

    // Find the start edge, then sample each bit in its middle
    task automatic capture_serial(output logic [7:0] b);
        int n;
        n = 0;
        b = 8'h00;
        while (tx && n < 3 * divider) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (!tx) else begin
            other_errors++;
            $display("ERROR at %0d ns: no start bit appeared on tx", $time);
        end
        repeat (divider / 2) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (divider) @(posedge clk);
            b[i] = tx;
        end
        repeat (divider) @(posedge clk);
        check_value(8'(tx), 8'h01, "tx stop bit");
    endtask

    // Software-style polling of the busy flag
    task automatic wait_tx_idle();
        logic [7:0] st;
        int n;
        st = st_busy;
        n = 0;
        while (st[stat_tx_busy] && n < 4 * divider) begin
            bus_read(addr_status, st);
            n++;
        end
        assert (!st[stat_tx_busy]) else begin
            other_errors++;
            $display("ERROR at %0d ns: tx_busy never cleared after a frame", $time);
        end
    endtask

    task automatic watchdog(input longint limit_ns);
        #(limit_ns);
        $display("ERROR: timeout, the tests did not finish within %0d ns", limit_ns);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    initial begin
        logic [7:0] got;
        logic [7:0] st;
        logic [7:0] burst [$];
        logic       line_busy;
        int         frames;
        int         assert_errors;

        sel   = 1'b0;
        we    = 1'b0;
        addr  = addr_data;
        wdata = 8'h00;
        rx    = 1'b1;

        rows[0] = '{op_transmit, 8'ha5, 8'd1, st_busy};
        rows[1] = '{op_receive, 8'h5a, 8'd1, st_avail};
        rows[2] = '{op_transmit, 8'h3c, 8'd1, st_busy};
        rows[3] = '{op_busy_write, 8'hc3, 8'd1, st_busy};
        rows[4] = '{op_burst, 8'h00, 8'(fifo_depth + 2), st_avail | st_ovf};
        rows[5] = '{op_receive, 8'h81, 8'd1, st_avail};

        // Twelve bit periods per frame plus bus and idle-check margin per row
        frames = 0;
        foreach (rows[r]) frames += rows[r].count;
        fork
            watchdog(longint'(frames * 12 * divider + 200 * n_rows) * 10);
        join_none

        @(posedge rst_n);
        check_value(8'(tx), 8'h01, "tx idle after reset");
        bus_read(addr_status, got);
        check_value(got, 8'h00, "status after reset");

        foreach (rows[r]) begin
            case (rows[r].op)
                op_transmit, op_busy_write: begin
                    bus_write(addr_data, rows[r].data);
                    fork
                        begin
                            capture_serial(got);
                            check_value(got, rows[r].data, "byte decoded from tx");
                        end
                        begin
                            repeat (3 * divider) @(posedge clk);
                            // Second byte lands mid frame and must be dropped
                            if (rows[r].op == op_busy_write) bus_write(addr_data, ~rows[r].data);
                            bus_read(addr_status, st);
                            check_value(st, rows[r].status, "status during frame");
                        end
                    join
                    wait_tx_idle();
                    if (rows[r].op == op_busy_write) begin
                        line_busy = 1'b0;
                        repeat (12 * divider) begin
                            @(posedge clk);
                            #1;
                            line_busy = line_busy | !tx;
                        end
                        assert (!line_busy) else begin
                            other_errors++;
                            $display("ERROR at %0d ns: a write during a busy frame was sent",
                                     $time);
                        end
                    end
                end
                op_receive: begin
                    send_serial(rows[r].data);
                    bus_read(addr_status, got);
                    check_value(got, rows[r].status, "status after received frame");
                    bus_read(addr_data, got);
                    check_value(got, rows[r].data, "received byte");
                    bus_read(addr_status, got);
                    check_value(got, 8'h00, "status after data read");
                    // Empty FIFO reads as zero and leaves status alone
                    bus_read(addr_data, got);
                    check_value(got, 8'h00, "data read of empty FIFO");
                    bus_read(addr_status, got);
                    check_value(got, 8'h00, "status after empty read");
                end
                op_burst: begin
                    burst.delete();
                    for (int i = 0; i < rows[r].count; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        burst.push_back(lcg_state[23:16]);
                        send_serial(lcg_state[23:16]);
                    end
                    bus_read(addr_status, got);
                    check_value(got, rows[r].status, "status after burst");
                    // Only the first fifo_depth bytes survive and come out oldest first
                    for (int i = 0; i < fifo_depth; i++) begin
                        bus_read(addr_data, got);
                        check_value(got, burst[i], "burst byte order");
                    end
                    bus_read(addr_status, got);
                    check_value(got, st_ovf, "overflow held after drain");
                    bus_write(addr_status, 8'h00);
                    bus_read(addr_status, got);
                    check_value(got, 8'h00, "status after overflow clear");
                end
                default: begin
                    other_errors++;
                    $display("ERROR: unknown operation in row %0d", r);
                end
            endcase
        end

        assert_errors = i_uart_periph.i_uart_core.i_uart_core_asserts.fail_count;
        $display("Error counts: %0d value, %0d protocol, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_uart_periph

//--- filelist.f
hdl/uart_pkg.sv
hdl/bus_pkg.sv
hdl/uart_core.sv
hdl/uart_rx_fifo.sv
hdl/uart_regs.sv
hdl/uart_periph.sv
verif/tb_clock_gen.sv
verif/uart_core_asserts.sv
verif/tb_uart_periph.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_uart_periph -f filelist.f \
    --Mdir obj_dir -o sim_uart_periph

status=0
./obj_dir/sim_uart_periph +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Result: failing run"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Result: simulation ended abnormally"
    exit 1
fi
echo "Result: passing run"
